//--- common/isa_pkg.sv
// ISA constants, operation codes and the R/I-type instruction formats with their union
`default_nettype none

package isa_pkg;

	localparam int xlen = 32;
	localparam int reg_count = 32;
	localparam int reg_addr_w = $clog2(reg_count);

	// Major opcodes accepted by the back end
	localparam logic [6:0] opcode_op = 7'b0110011;
	localparam logic [6:0] opcode_op_imm = 7'b0010011;

	localparam logic [6:0] funct7_base = 7'b0000000;
	localparam logic [6:0] funct7_alt = 7'b0100000;     // sub, sra and srai
	localparam logic [6:0] funct7_muldiv = 7'b0000001;

	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_and  = 4'd2,
		alu_or   = 4'd3,
		alu_xor  = 4'd4,
		alu_sll  = 4'd5,
		alu_srl  = 4'd6,
		alu_sra  = 4'd7,
		alu_slt  = 4'd8,
		alu_sltu = 4'd9
	} alu_op_e;

	// Values follow funct3[1:0] of the M extension
	typedef enum logic [1:0] {
		mul_mul    = 2'd0,
		mul_mulh   = 2'd1,
		mul_mulhsu = 2'd2,
		mul_mulhu  = 2'd3
	} mul_op_e;

	typedef struct packed {
		logic [6:0]            funct7;
		logic [reg_addr_w-1:0] rs2;
		logic [reg_addr_w-1:0] rs1;
		logic [2:0]            funct3;
		logic [reg_addr_w-1:0] rd;
		logic [6:0]            opcode;
	} r_format_t;

	typedef struct packed {
		logic [11:0]           imm12;
		logic [reg_addr_w-1:0] rs1;
		logic [2:0]            funct3;
		logic [reg_addr_w-1:0] rd;
		logic [6:0]            opcode;
	} i_format_t;

	// Same instruction word seen in either format
	typedef union packed {
		r_format_t r;
		i_format_t i;
	} instr_u;

endpackage

`default_nettype wire

//--- common/pipe_pkg.sv
// Pipeline records for issue, ALU and multiplier requests, writeback, and multiplier latency
`default_nettype none

package pipe_pkg;

	import isa_pkg::*;

	localparam int mult_stages = 5;

	typedef struct packed {
		logic            valid;
		instr_u          instr;
		logic [xlen-1:0] pc;
	} issue_t;

	typedef struct packed {
		logic                  valid;     // Also the write enable of the result
		alu_op_e               op;
		logic [xlen-1:0]       a;
		logic [xlen-1:0]       b;
		logic [reg_addr_w-1:0] rd;
		logic [xlen-1:0]       instr;
		logic [xlen-1:0]       pc;
	} alu_req_t;

	typedef struct packed {
		logic                  valid;
		mul_op_e               op;
		logic [xlen-1:0]       a;
		logic [xlen-1:0]       b;
		logic [reg_addr_w-1:0] rd;
		logic [xlen-1:0]       instr;
		logic [xlen-1:0]       pc;
	} mul_req_t;

	typedef struct packed {
		logic                  we;
		logic [reg_addr_w-1:0] addr;
		logic [xlen-1:0]       data;
		logic [xlen-1:0]       instr;
		logic [xlen-1:0]       pc;
	} wb_entry_t;

endpackage

`default_nettype wire

//--- source/issue_stage.sv
// Issue stage with register file, operand read, immediate decode and unit selection
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
	input  wire                 clk_i,
	input  wire                 reset_i,
	input  wire                 kill_i,
	input  pipe_pkg::issue_t    issue_i,
	input  pipe_pkg::wb_entry_t wb_i,
	output pipe_pkg::alu_req_t  alu_req_o,
	output pipe_pkg::mul_req_t  mul_req_o
);

	import isa_pkg::*;
	import pipe_pkg::*;

	logic [xlen-1:0] regs [1:reg_count-1];   // x0 is not stored

	instr_u          instr;
	logic [xlen-1:0] rs1_val;
	logic [xlen-1:0] rs2_val;
	logic [xlen-1:0] imm;
	logic            alu_ok;
	logic            is_mul;
	alu_op_e         alu_op;
	alu_req_t        alu_d;
	mul_req_t        mul_d;

	function automatic logic [xlen-1:0] rf_read(input logic [reg_addr_w-1:0] addr);
		rf_read = (addr == '0) ? '0 : regs[addr];
	endfunction

	// Returns whether funct3/funct7 name an ALU operation, imm selects the I-type rules
	function automatic logic alu_decode(input logic [2:0] f3, input logic [6:0] f7,
			input logic use_imm, output alu_op_e op);
		logic base;
		logic alt;
		base = (f7 == funct7_base);
		alt = (f7 == funct7_alt);
		alu_decode = use_imm || base;
		unique case (f3)
			3'b000: begin
				op = (alt && !use_imm) ? alu_sub : alu_add;
				alu_decode = use_imm || base || alt;
			end
			3'b001: begin
				op = alu_sll;
				alu_decode = base;
			end
			3'b010: op = alu_slt;
			3'b011: op = alu_sltu;
			3'b100: op = alu_xor;
			3'b101: begin
				op = alt ? alu_sra : alu_srl;
				alu_decode = base || alt;
			end
			3'b110: op = alu_or;
			default: op = alu_and;
		endcase
	endfunction

	// Written at the edge where the result shows on wb, so a same-cycle read sees the old value
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int k = 1; k < reg_count; k++)
				regs[k] <= '0;
		end else if (wb_i.we && wb_i.addr != '0) begin
			regs[wb_i.addr] <= wb_i.data;
		end
	end

	always_comb begin
		instr = issue_i.instr;
		rs1_val = rf_read(instr.r.rs1);
		rs2_val = rf_read(instr.r.rs2);
		imm = {{(xlen-12){instr.i.imm12[11]}}, instr.i.imm12};
		alu_ok = 1'b0;
		alu_op = alu_add;
		is_mul = 1'b0;
		if (instr.r.opcode == opcode_op) begin
			if (instr.r.funct7 == funct7_muldiv)
				is_mul = !instr.r.funct3[2];   // Divide and remainder are not handled
			else
				alu_ok = alu_decode(instr.r.funct3, instr.r.funct7, 1'b0, alu_op);
		end else if (instr.i.opcode == opcode_op_imm) begin
			alu_ok = alu_decode(instr.i.funct3, instr.i.imm12[11:5], 1'b1, alu_op);
		end

		// rd zero leaves the request without write enable
		alu_d.valid = issue_i.valid && alu_ok && instr.r.rd != '0;
		alu_d.op = alu_op;
		alu_d.a = rs1_val;
		alu_d.b = (instr.i.opcode == opcode_op_imm) ? imm : rs2_val;
		alu_d.rd = instr.r.rd;
		alu_d.instr = instr;
		alu_d.pc = issue_i.pc;

		mul_d.valid = issue_i.valid && is_mul && instr.r.rd != '0;
		mul_d.op = mul_op_e'(instr.r.funct3[1:0]);
		mul_d.a = rs1_val;
		mul_d.b = rs2_val;
		mul_d.rd = instr.r.rd;
		mul_d.instr = instr;
		mul_d.pc = issue_i.pc;
	end

	always_ff @(posedge clk_i) begin
		alu_req_o <= alu_d;
		mul_req_o <= mul_d;
		if (reset_i || kill_i) begin
			alu_req_o.valid <= 1'b0;
			mul_req_o.valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- execute/alu_unit.sv
// Single-cycle integer ALU with registered writeback record
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
	input  wire                 clk_i,
	input  wire                 reset_i,
	input  wire                 kill_i,
	input  pipe_pkg::alu_req_t  alu_req_i,
	output pipe_pkg::wb_entry_t alu_wb_o
);

	import isa_pkg::*;

	logic [xlen-1:0] a;
	logic [xlen-1:0] b;
	logic [4:0]      shamt;
	logic            lt_signed;
	logic            lt_unsigned;
	logic [xlen-1:0] result;

	assign a = alu_req_i.a;
	assign b = alu_req_i.b;
	assign shamt = b[4:0];   // Only the low five bits shift
	assign lt_signed = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		unique case (alu_req_i.op)
			alu_add:  result = a + b;
			alu_sub:  result = a - b;
			alu_and:  result = a & b;
			alu_or:   result = a | b;
			alu_xor:  result = a ^ b;
			alu_sll:  result = a << shamt;
			alu_srl:  result = a >> shamt;
			alu_sra:  result = $signed(a) >>> shamt;
			alu_slt:  result = {{(xlen-1){1'b0}}, lt_signed};
			alu_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned};
			default:  result = '0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		alu_wb_o.we <= alu_req_i.valid;
		alu_wb_o.addr <= alu_req_i.rd;
		alu_wb_o.data <= result;
		alu_wb_o.instr <= alu_req_i.instr;
		alu_wb_o.pc <= alu_req_i.pc;
		if (reset_i || kill_i)
			alu_wb_o.we <= 1'b0;
	end

endmodule

`default_nettype wire

//--- multiplier/mult_pipeline.sv
// Five-stage 32x32 multiplier for mul, mulh, mulhsu and mulhu
`timescale 1ns/1ps
`default_nettype none

module mult_pipeline (
	input  wire                 clk_i,
	input  wire                 reset_i,
	input  wire                 kill_i,
	input  pipe_pkg::mul_req_t  mul_req_i,
	output pipe_pkg::wb_entry_t mul_wb_o
);

	import isa_pkg::*;
	import pipe_pkg::*;

	typedef struct packed {
		logic                  valid;
		mul_op_e               op;
		logic [reg_addr_w-1:0] rd;
		logic [xlen-1:0]       instr;
		logic [xlen-1:0]       pc;
	} mul_meta_t;

	mul_meta_t meta_q [1:mult_stages-1];   // Stages one to four

	logic               sign_a;
	logic               sign_b;
	logic signed [32:0] s1_a;
	logic signed [32:0] s1_b;
	logic        [31:0] pp_ll;
	logic signed [33:0] pp_lh;
	logic signed [33:0] pp_hl;
	logic signed [33:0] pp_hh;
	logic signed [63:0] s2_acc;
	logic signed [63:0] s3_acc;
	logic signed [63:0] s4_acc;
	logic signed [63:0] lh_w;
	logic signed [63:0] hl_w;
	logic signed [63:0] hh_w;
	logic signed [33:0] s2_lh;
	logic signed [16:0] s2_a_hi;
	logic signed [16:0] s3_a_hi;
	logic signed [16:0] s2_b_hi;
	logic signed [16:0] s3_b_hi;
	logic        [15:0] s2_b_lo;

	// Operand a is unsigned only for mulhu
	assign sign_a = (mul_req_i.op != mul_mulhu) && mul_req_i.a[31];
	assign sign_b = (mul_req_i.op == mul_mul || mul_req_i.op == mul_mulh) && mul_req_i.b[31];

	assign pp_ll = {16'b0, s1_a[15:0]} * {16'b0, s1_b[15:0]};
	assign pp_lh = $signed({1'b0, s1_a[15:0]}) * $signed(s1_b[32:16]);
	assign pp_hl = s2_a_hi * $signed({1'b0, s2_b_lo});
	assign pp_hh = s3_a_hi * s3_b_hi;
	assign lh_w = s2_lh;   // Sign-extended to the accumulator
	assign hl_w = pp_hl;
	assign hh_w = pp_hh;

	always_ff @(posedge clk_i) begin
		s1_a <= {sign_a, mul_req_i.a};
		s1_b <= {sign_b, mul_req_i.b};
		s2_acc <= {32'b0, pp_ll};
		s2_lh <= pp_lh;
		s2_a_hi <= s1_a[32:16];
		s2_b_hi <= s1_b[32:16];
		s2_b_lo <= s1_b[15:0];
		s3_acc <= s2_acc + (lh_w <<< 16) + (hl_w <<< 16);   // Cross terms
		s3_a_hi <= s2_a_hi;
		s3_b_hi <= s2_b_hi;
		s4_acc <= s3_acc + (hh_w <<< 32);
	end

	always_ff @(posedge clk_i) begin
		meta_q[1] <= {mul_req_i.valid, mul_req_i.op, mul_req_i.rd, mul_req_i.instr,
			mul_req_i.pc};
		for (int k = 2; k < mult_stages; k++)
			meta_q[k] <= meta_q[k-1];
		mul_wb_o.we <= meta_q[mult_stages-1].valid;
		mul_wb_o.addr <= meta_q[mult_stages-1].rd;
		mul_wb_o.data <= (meta_q[mult_stages-1].op == mul_mul) ? s4_acc[31:0] : s4_acc[63:32];
		mul_wb_o.instr <= meta_q[mult_stages-1].instr;
		mul_wb_o.pc <= meta_q[mult_stages-1].pc;
		if (reset_i || kill_i) begin
			for (int k = 1; k < mult_stages; k++)
				meta_q[k].valid <= 1'b0;
			mul_wb_o.we <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- source/exe_write_latch.sv
// Execute-to-writeback latch merging ALU and multiplier results by priority
`timescale 1ns/1ps
`default_nettype none

module exe_write_latch (
	input  wire                 clk_i,
	input  wire                 reset_i,
	input  wire                 kill_i,
	input  pipe_pkg::wb_entry_t alu_wb_i,
	input  pipe_pkg::wb_entry_t mul_wb_i,
	output pipe_pkg::wb_entry_t wb_o
);

	// ALU result wins over a colliding multiply
	always_ff @(posedge clk_i) begin
		if (reset_i || kill_i) begin
			wb_o <= '0;
		end else if (alu_wb_i.we) begin
			wb_o <= alu_wb_i;
		end else if (mul_wb_i.we) begin
			wb_o <= mul_wb_i;
		end else begin
			wb_o <= '0;   // Idle slot shows an empty record
		end
	end

endmodule

`default_nettype wire

//--- source/backend_top.sv
// Integer back end top level with issue stage, ALU, multiplier and writeback latch
`timescale 1ns/1ps
`default_nettype none

module backend_top (
	input  wire                 clk_i,
	input  wire                 reset_i,
	input  wire                 kill_i,
	input  pipe_pkg::issue_t    issue_i,
	output pipe_pkg::wb_entry_t wb_o
);

	import pipe_pkg::*;

	alu_req_t  alu_req;
	mul_req_t  mul_req;
	wb_entry_t alu_wb;
	wb_entry_t mul_wb;

	// wb_o also serves as the register write port
	issue_stage issue_stage_inst (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.kill_i    (kill_i),
		.issue_i   (issue_i),
		.wb_i      (wb_o),
		.alu_req_o (alu_req),
		.mul_req_o (mul_req)
	);

	alu_unit alu_unit_inst (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.kill_i    (kill_i),
		.alu_req_i (alu_req),
		.alu_wb_o  (alu_wb)
	);

	mult_pipeline mult_pipeline_inst (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.kill_i    (kill_i),
		.mul_req_i (mul_req),
		.mul_wb_o  (mul_wb)
	);

	exe_write_latch exe_write_latch_inst (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.kill_i   (kill_i),
		.alu_wb_i (alu_wb),
		.mul_wb_i (mul_wb),
		.wb_o     (wb_o)
	);

endmodule

`default_nettype wire

//--- testbench/backend_model.svh
// Shadow register file with reference results for ALU and multiply instructions

logic [31:0] shadow [0:31] = '{default: 32'd0};

function automatic logic [31:0] reg_value(input logic [4:0] r);
	return (r == 5'd0) ? 32'd0 : shadow[r];   // x0 always reads zero
endfunction

function automatic void write_shadow(input logic [4:0] r, input logic [31:0] v);
	if (r != 5'd0)
		shadow[r] = v;
endfunction

// Register or immediate form, chosen by the opcode
function automatic logic [31:0] alu_model(input logic [31:0] word, input logic [31:0] x,
		input logic [31:0] y_reg);
	logic        imm_form;
	logic [31:0] y;
	logic [31:0] sra_val;
	imm_form = (word[6:0] == opcode_op_imm);
	y = imm_form ? {{20{word[31]}}, word[31:20]} : y_reg;
	sra_val = $signed(x) >>> y[4:0];
	case (word[14:12])
		3'b000: return (!imm_form && word[30]) ? x - y : x + y;
		3'b001: return x << y[4:0];
		3'b010: return {31'd0, $signed(x) < $signed(y)};
		3'b011: return {31'd0, x < y};
		3'b100: return x ^ y;
		3'b101: return word[30] ? sra_val : x >> y[4:0];   // Bit 30 picks arithmetic
		3'b110: return x | y;
		default: return x & y;
	endcase
endfunction

// Full product with each operand signed or unsigned as funct3 says
function automatic logic [31:0] mul_model(input logic [2:0] f3, input logic [31:0] x,
		input logic [31:0] y);
	logic signed [65:0] sx;
	logic signed [65:0] sy;
	logic signed [65:0] prod;
	sx = (f3[1:0] == 2'b11) ? {34'd0, x} : {{34{x[31]}}, x};
	sy = (f3[1:0] == 2'b10 || f3[1:0] == 2'b11) ? {34'd0, y} : {{34{y[31]}}, y};
	prod = sx * sy;
	return (f3[1:0] == 2'b00) ? prod[31:0] : prod[63:32];   // mul keeps the low word
endfunction

//--- testbench/backend_tb.sv
// Back end testbench with stimulus, scoreboard, assertion checks, watchdog and report
`timescale 1ns/1ps
`default_nettype none

module backend_tb;

	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int reset_cycles = 16;
	localparam int alu_latency = 3;   // Issue cycle to wb_o
	localparam int mul_latency = 7;
	localparam int random_count = 200;
	localparam int issue_total = random_count + 30;
	localparam int watchdog_cycles = issue_total * 12 + reset_cycles;

	logic      clk;
	logic      reset;
	logic      kill;
	issue_t    issue;
	wb_entry_t wb;

	wb_entry_t   exp_q [int];   // Keyed by the edge count at which wb_o shows it
	wb_entry_t   exp_wb = '0;
	int          edge_cnt = 0;
	logic        started = 1'b0;
	logic [31:0] pc = 32'h0000_1000;
	int          empty_errs = 0;
	int          data_errs = 0;
	int          tag_errs = 0;

	`include "backend_model.svh"

	backend_top backend_top_inst (
		.clk_i   (clk),
		.reset_i (reset),
		.kill_i  (kill),
		.issue_i (issue),
		.wb_o    (wb)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// The record shown since the last edge lands in the register file at this one
	always @(posedge clk) begin
		if (exp_q.exists(edge_cnt)) begin
			write_shadow(exp_q[edge_cnt].addr, exp_q[edge_cnt].data);
			exp_q.delete(edge_cnt);
		end
		edge_cnt = edge_cnt + 1;
		started = 1'b1;
		exp_wb = exp_q.exists(edge_cnt) ? exp_q[edge_cnt] : '0;
	end

	assert property (@(negedge clk) disable iff (!started) !exp_wb.we |-> wb == '0)
	else begin
		empty_errs = empty_errs + 1;
		$display("Error %0d ns: empty slot carries record %h", $time, wb);
	end

	assert property (@(negedge clk) disable iff (!started)
			exp_wb.we |-> wb.we && wb.data == exp_wb.data)
	else begin
		data_errs = data_errs + 1;
		$display("Error %0d ns: result we %b data %h, expected %h", $time, wb.we, wb.data,
			exp_wb.data);
	end

	assert property (@(negedge clk) disable iff (!started)
			exp_wb.we |-> wb.addr == exp_wb.addr && wb.instr == exp_wb.instr && wb.pc == exp_wb.pc)
	else begin
		tag_errs = tag_errs + 1;
		$display("Error %0d ns: result rd %0d instr %h pc %h, expected rd %0d instr %h pc %h",
			$time, wb.addr, wb.instr, wb.pc, exp_wb.addr, exp_wb.instr, exp_wb.pc);
	end

	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, opcode_op};
	endfunction

	function automatic logic [31:0] i_word(input logic [2:0] f3, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, opcode_op_imm};
	endfunction

	function automatic logic [4:0] rand_reg();
		return 5'($urandom);
	endfunction

	task automatic send(input logic [31:0] word);
		wb_entry_t e;
		logic      is_mul;
		@(negedge clk);
		is_mul = (word[6:0] == opcode_op) && (word[31:25] == funct7_muldiv);
		issue.valid = 1'b1;
		issue.instr = word;
		issue.pc = pc;
		e.we = 1'b1;
		e.addr = word[11:7];
		e.data = is_mul ? mul_model(word[14:12], reg_value(word[19:15]), reg_value(word[24:20]))
			: alu_model(word, reg_value(word[19:15]), reg_value(word[24:20]));
		e.instr = word;
		e.pc = pc;
		if (e.addr != 5'd0)
			exp_q[edge_cnt + (is_mul ? mul_latency : alu_latency)] = e;   // A later ALU wins
		pc = pc + 32'd4;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			issue.valid = 1'b0;
		end
	endtask

	task automatic kill_pipeline();
		@(negedge clk);
		issue.valid = 1'b0;
		kill = 1'b1;
		for (int d = edge_cnt + 1; d <= edge_cnt + mul_latency; d++)
			if (exp_q.exists(d))
				exp_q.delete(d);
		@(negedge clk);
		kill = 1'b0;
	endtask

	task automatic send_random_alu();
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [11:0] imm;
		f3 = 3'($urandom);
		f7 = ((f3 == 3'b000 || f3 == 3'b101) && $urandom % 2 == 1) ? funct7_alt : funct7_base;
		imm = 12'($urandom);
		if (f3 == 3'b001 || f3 == 3'b101)
			imm[11:5] = f7;   // Shift immediates carry the shift type above the amount
		if ($urandom % 2 == 1)
			send(r_word(f7, f3, rand_reg(), rand_reg(), rand_reg()));
		else
			send(i_word(f3, rand_reg(), rand_reg(), imm));
	endtask

	initial begin
		void'($urandom(41));
		reset = 1'b1;
		kill = 1'b0;
		issue = '0;
		repeat (reset_cycles) @(negedge clk);
		reset = 1'b0;

		send(i_word(3'b000, 5'd1, 5'd0, 12'hfff));   // x1 = -1
		send(i_word(3'b000, 5'd2, 5'd0, 12'h001));
		send(i_word(3'b000, 5'd13, 5'd0, 12'h05a));
		idle(3);
		send(i_word(3'b001, 5'd2, 5'd2, 12'd31));   // 0x80000000
		send(i_word(3'b101, 5'd3, 5'd1, 12'd0));
		idle(3);
		send(r_word(funct7_base, 3'b010, 5'd4, 5'd2, 5'd1));
		send(r_word(funct7_base, 3'b011, 5'd5, 5'd2, 5'd3));
		send(r_word(funct7_alt, 3'b101, 5'd6, 5'd2, 5'd3));   // sra by 31
		send(r_word(funct7_base, 3'b000, 5'd0, 5'd1, 5'd1));   // No write to x0
		idle(3);
		send(r_word(funct7_base, 3'b000, 5'd12, 5'd0, 5'd6));

		// Five multiplies in flight
		send(r_word(funct7_muldiv, 3'b000, 5'd7, 5'd1, 5'd2));
		send(r_word(funct7_muldiv, 3'b001, 5'd8, 5'd2, 5'd2));
		send(r_word(funct7_muldiv, 3'b010, 5'd9, 5'd2, 5'd1));
		send(r_word(funct7_muldiv, 3'b011, 5'd10, 5'd1, 5'd1));
		send(r_word(funct7_muldiv, 3'b001, 5'd11, 5'd1, 5'd2));
		idle(7);

		// ALU four cycles behind a multiply takes its writeback slot
		send(r_word(funct7_muldiv, 3'b000, 5'd13, 5'd1, 5'd1));
		idle(3);
		send(r_word(funct7_base, 3'b100, 5'd14, 5'd2, 5'd1));
		idle(7);
		send(r_word(funct7_base, 3'b110, 5'd15, 5'd13, 5'd0));

		send(r_word(funct7_muldiv, 3'b011, 5'd7, 5'd2, 5'd1));
		send(i_word(3'b100, 5'd4, 5'd1, 12'h123));
		kill_pipeline();
		idle(3);
		send(r_word(funct7_base, 3'b000, 5'd16, 5'd7, 5'd4));   // Old x7 and x4
		idle(3);

		repeat (random_count) begin
			if ($urandom % 4 == 0)
				send(r_word(funct7_muldiv, {1'b0, 2'($urandom)}, rand_reg(), rand_reg(), rand_reg()));
			else
				send_random_alu();
			idle($urandom % 3);
		end
		kill_pipeline();
		idle(mul_latency + 2);

		$display("Errors: empty slot %0d, result data %0d, result tag %0d",
			empty_errs, data_errs, tag_errs);
		if (empty_errs + data_errs + tag_errs == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog timeout: the run did not finish within %0d cycles", watchdog_cycles);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- backend.f
+incdir+testbench
common/isa_pkg.sv
common/pipe_pkg.sv
source/issue_stage.sv
execute/alu_unit.sv
multiplier/mult_pipeline.sv
source/exe_write_latch.sv
source/backend_top.sv
testbench/backend_tb.sv

//--- Makefile
# Verilator build and run of the integer back end testbench

VERILATOR ?= verilator
TOP       ?= backend_tb
FILELIST  ?= backend.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
